/* hdl/sme_char_pkg.sv */
package sme_char_pkg;

    // one ascii character
    typedef logic [7:0] char_t;

    // characters with a meaning in a pattern
    localparam char_t CHAR_HAT = 8'h5e;
    localparam char_t CHAR_DOLLAR = 8'h24;
    localparam char_t CHAR_DOT = 8'h2e;

    // underscore separates words in the string
    localparam char_t CHAR_SPACE = 8'h5f;

    // empty slot that matches anything in the body
    localparam char_t CHAR_NONE = 8'h00;

endpackage

/* hdl/sme_cfg_pkg.sv */
package sme_cfg_pkg;

    // default geometry of the engine
    localparam int STRING_LENGTH_DEF = 32;
    localparam int PATTERN_LENGTH_DEF = 8;

    // main sequencer states
    typedef enum logic [2:0]
    {
        ST_IDLE,
        ST_LOAD_STRING,
        ST_LOAD_PATTERN,
        ST_SEARCH,
        ST_REPORT
    } sme_state_e;

    // anchors removed from the pattern
    typedef struct packed
    {
        logic anchor_start;
        logic anchor_end;
    } pattern_flags_t;

endpackage

/* hdl/sme_control.sv */
`timescale 1ns/10ps

module sme_control (
    input  logic clk,
    input  logic reset,
    input  logic isstring,
    input  logic ispattern,
    input  logic search_done,
    output logic string_clear,
    output logic string_write,
    output logic pattern_clear,
    output logic pattern_write,
    output logic search_start,
    output logic valid
);
    import sme_cfg_pkg::*;

    sme_state_e state;
    sme_state_e state_next;
    logic accept;
    logic in_string;

    // a new burst may begin here
    assign accept = (state == ST_IDLE) || (state == ST_REPORT);
    assign in_string = state == ST_LOAD_STRING;

    assign string_clear = isstring && accept;
    assign string_write = isstring && (accept || in_string);
    // string wins when both strobes show up together
    assign pattern_clear = ispattern && !isstring && (accept || in_string);
    assign pattern_write = pattern_clear || (ispattern && state == ST_LOAD_PATTERN);
    assign search_start = (state == ST_LOAD_PATTERN) && !ispattern;
    assign valid = state == ST_REPORT;

    always_comb
    begin
        state_next = state;
        case (state)
            ST_IDLE, ST_LOAD_STRING, ST_REPORT:
            begin
                if (isstring)
                    state_next = ST_LOAD_STRING;
                else if (ispattern)
                    state_next = ST_LOAD_PATTERN;
                else
                    state_next = ST_IDLE;
            end
            ST_LOAD_PATTERN:
            begin
                state_next = ispattern ? ST_LOAD_PATTERN : ST_SEARCH;
            end
            ST_SEARCH:
            begin
                state_next = search_done ? ST_REPORT : ST_SEARCH;
            end
            default:
            begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= ST_IDLE;
        else
            state <= state_next;
    end

    // result is presented for a single cycle only
    a_valid_pulse: assert property (@(posedge clk) disable iff (reset) valid |=> !valid);

endmodule

/* hdl/string_buffer.sv */
`timescale 1ns/10ps

module string_buffer #(
    parameter int STRING_LENGTH = sme_cfg_pkg::STRING_LENGTH_DEF,
    parameter int PATTERN_LENGTH = sme_cfg_pkg::PATTERN_LENGTH_DEF,
    localparam int LEN_W = $clog2(STRING_LENGTH + 1)
) (
    input  logic clk,
    input  logic reset,
    input  sme_char_pkg::char_t chardata,
    input  logic string_clear,
    input  logic string_write,
    input  logic [LEN_W-1:0] window_pos,
    output sme_char_pkg::char_t [PATTERN_LENGTH+1:0] window,
    output logic [LEN_W-1:0] string_length
);
    import sme_char_pkg::*;

    localparam int IDX_W = (STRING_LENGTH > 1) ? $clog2(STRING_LENGTH) : 1;

    char_t mem [STRING_LENGTH];
    logic [IDX_W-1:0] wr_addr;
    logic room;

    assign wr_addr = string_clear ? '0 : string_length[IDX_W-1:0];
    assign room = string_clear || (string_length < STRING_LENGTH);

    always_ff @(posedge clk)
    begin
        if (string_write && room)
            mem[wr_addr] <= chardata;
    end

    // write counter doubles as the length
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            string_length <= '0;
        else if (string_write && room)
            string_length <= string_clear ? LEN_W'(1) : string_length + 1'b1;
    end

    // window starts one character before window_pos
    always_comb
    begin
        int pos;
        for (int k = 0; k < PATTERN_LENGTH + 2; k++)
        begin
            pos = int'(window_pos) + k - 1;
            if (pos >= 0 && pos < int'(string_length))
                window[k] = mem[pos[IDX_W-1:0]];
            else
                window[k] = CHAR_NONE;
        end
    end

    // the sequencer must not push past the end of the buffer
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        string_write && !string_clear |-> string_length < STRING_LENGTH);

endmodule

/* hdl/pattern_loader.sv */
`timescale 1ns/10ps

module pattern_loader #(
    parameter int PATTERN_LENGTH = sme_cfg_pkg::PATTERN_LENGTH_DEF,
    localparam int BL_W = $clog2(PATTERN_LENGTH + 1)
) (
    input  logic clk,
    input  logic reset,
    input  sme_char_pkg::char_t chardata,
    input  logic pattern_clear,
    input  logic pattern_write,
    output sme_char_pkg::char_t [PATTERN_LENGTH-1:0] body,
    output logic [BL_W-1:0] body_length,
    output sme_cfg_pkg::pattern_flags_t flags
);
    import sme_char_pkg::*;

    logic dollar_held;
    logic first_hat;
    logic base_held;
    logic [BL_W-1:0] base_len;
    logic [BL_W-1:0] lit_len;

    assign first_hat = pattern_clear && (chardata == CHAR_HAT);

    // first char of a burst starts from an empty body
    assign base_len = pattern_clear ? '0 : body_length;
    assign base_held = pattern_clear ? 1'b0 : dollar_held;
    // slot after a committed dollar
    assign lit_len = base_len + BL_W'(base_held);

    always_ff @(posedge clk)
    begin
        if (pattern_clear)
            body <= {PATTERN_LENGTH{CHAR_NONE}};
        if (pattern_write && !first_hat)
        begin
            // held dollar turned out not to be last
            if (base_held)
                body[base_len] <= CHAR_DOLLAR;
            if (chardata != CHAR_DOLLAR)
                body[lit_len] <= chardata;
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            body_length <= '0;
            flags <= '0;
            dollar_held <= 1'b0;
        end
        else
        begin
            if (pattern_clear)
                flags <= '0;
            if (pattern_write)
            begin
                if (first_hat)
                begin
                    flags.anchor_start <= 1'b1;
                    body_length <= '0;
                    dollar_held <= 1'b0;
                end
                else if (chardata == CHAR_DOLLAR)
                begin
                    dollar_held <= 1'b1;
                    body_length <= lit_len;
                end
                else
                begin
                    dollar_held <= 1'b0;
                    body_length <= lit_len + 1'b1;
                end
            end
            else if (dollar_held)
            begin
                // burst ended on a dollar
                flags.anchor_end <= 1'b1;
                dollar_held <= 1'b0;
            end
        end
    end

    a_body_fits: assert property (@(posedge clk) disable iff (reset)
        pattern_write |=> body_length <= PATTERN_LENGTH);

endmodule

/* hdl/match_scanner.sv */
`timescale 1ns/10ps

module match_scanner #(
    parameter int STRING_LENGTH = sme_cfg_pkg::STRING_LENGTH_DEF,
    parameter int PATTERN_LENGTH = sme_cfg_pkg::PATTERN_LENGTH_DEF,
    localparam int LEN_W = $clog2(STRING_LENGTH + 1),
    localparam int BL_W = $clog2(PATTERN_LENGTH + 1),
    localparam int IDX_W = (STRING_LENGTH > 1) ? $clog2(STRING_LENGTH) : 1
) (
    input  logic clk,
    input  logic reset,
    input  logic search_start,
    input  sme_char_pkg::char_t [PATTERN_LENGTH+1:0] window,
    input  logic [LEN_W-1:0] string_length,
    input  sme_char_pkg::char_t [PATTERN_LENGTH-1:0] body,
    input  logic [BL_W-1:0] body_length,
    input  sme_cfg_pkg::pattern_flags_t flags,
    output logic [LEN_W-1:0] window_pos,
    output logic search_done,
    output logic match,
    output logic [IDX_W-1:0] match_index
);
    import sme_char_pkg::*;

    logic searching;
    logic [PATTERN_LENGTH-1:0] slot_ok;
    logic start_ok;
    logic end_ok;
    logic fits;
    logic last_pos;
    logic hit;
    int end_pos;

    // string position just past the body
    assign end_pos = int'(window_pos) + int'(body_length);
    assign fits = end_pos <= int'(string_length);
    assign last_pos = end_pos >= int'(string_length);

    always_comb
    begin
        for (int j = 0; j < PATTERN_LENGTH; j++)
        begin
            slot_ok[j] = (body[j] == CHAR_DOT) || (body[j] == CHAR_NONE)
                || (body[j] == window[j + 1]);
        end
    end

    // window[0] is the character before the body
    assign start_ok = !flags.anchor_start || (window_pos == '0)
        || (window[0] == CHAR_SPACE);
    assign end_ok = !flags.anchor_end || (end_pos == int'(string_length))
        || (window[body_length + 1] == CHAR_SPACE);

    assign hit = fits && (&slot_ok) && start_ok && end_ok;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            searching <= 1'b0;
            window_pos <= '0;
            search_done <= 1'b0;
            match <= 1'b0;
            match_index <= '0;
        end
        else
        begin
            search_done <= 1'b0;
            if (search_start)
            begin
                searching <= 1'b1;
                window_pos <= '0;
            end
            else if (searching)
            begin
                if (hit)
                begin
                    searching <= 1'b0;
                    search_done <= 1'b1;
                    match <= 1'b1;
                    match_index <= window_pos[IDX_W-1:0];
                end
                else if (last_pos)
                begin
                    // also covers a body longer than the string
                    searching <= 1'b0;
                    search_done <= 1'b1;
                    match <= 1'b0;
                    match_index <= '0;
                end
                else
                begin
                    window_pos <= window_pos + 1'b1;
                end
            end
        end
    end

    a_pos_in_string: assert property (@(posedge clk) disable iff (reset)
        searching |-> window_pos <= string_length);

endmodule

/* hdl/sme_top.sv */
`timescale 1ns/10ps

module sme_top #(
    parameter int STRING_LENGTH = sme_cfg_pkg::STRING_LENGTH_DEF,
    parameter int PATTERN_LENGTH = sme_cfg_pkg::PATTERN_LENGTH_DEF,
    localparam int IDX_W = (STRING_LENGTH > 1) ? $clog2(STRING_LENGTH) : 1
) (
    input  logic clk,
    input  logic reset,
    input  sme_char_pkg::char_t chardata,
    input  logic isstring,
    input  logic ispattern,
    output logic valid,
    output logic match,
    output logic [IDX_W-1:0] match_index
);
    import sme_char_pkg::*;
    import sme_cfg_pkg::*;

    localparam int LEN_W = $clog2(STRING_LENGTH + 1);
    localparam int BL_W = $clog2(PATTERN_LENGTH + 1);

    logic string_clear;
    logic string_write;
    logic pattern_clear;
    logic pattern_write;
    logic search_start;
    logic search_done;
    logic [LEN_W-1:0] window_pos;
    logic [LEN_W-1:0] string_length;
    char_t [PATTERN_LENGTH+1:0] window;
    char_t [PATTERN_LENGTH-1:0] body;
    logic [BL_W-1:0] body_length;
    pattern_flags_t flags;

    sme_control u_control (
        .clk           (clk),
        .reset         (reset),
        .isstring      (isstring),
        .ispattern     (ispattern),
        .search_done   (search_done),
        .string_clear  (string_clear),
        .string_write  (string_write),
        .pattern_clear (pattern_clear),
        .pattern_write (pattern_write),
        .search_start  (search_start),
        .valid         (valid)
    );

    string_buffer #(
        .STRING_LENGTH  (STRING_LENGTH),
        .PATTERN_LENGTH (PATTERN_LENGTH)
    ) u_string_buffer (
        .clk           (clk),
        .reset         (reset),
        .chardata      (chardata),
        .string_clear  (string_clear),
        .string_write  (string_write),
        .window_pos    (window_pos),
        .window        (window),
        .string_length (string_length)
    );

    pattern_loader #(
        .PATTERN_LENGTH (PATTERN_LENGTH)
    ) u_pattern_loader (
        .clk           (clk),
        .reset         (reset),
        .chardata      (chardata),
        .pattern_clear (pattern_clear),
        .pattern_write (pattern_write),
        .body          (body),
        .body_length   (body_length),
        .flags         (flags)
    );

    match_scanner #(
        .STRING_LENGTH  (STRING_LENGTH),
        .PATTERN_LENGTH (PATTERN_LENGTH)
    ) u_match_scanner (
        .clk           (clk),
        .reset         (reset),
        .search_start  (search_start),
        .window        (window),
        .string_length (string_length),
        .body          (body),
        .body_length   (body_length),
        .flags         (flags),
        .window_pos    (window_pos),
        .search_done   (search_done),
        .match         (match),
        .match_index   (match_index)
    );

endmodule

/* sim/sme_cases.svh */
`ifndef SME_CASES_SVH
`define SME_CASES_SVH

// per case the string, the pattern, the expected match and the expected index
// an empty string keeps the string loaded before
localparam int NUM_CASES = 14;

string case_text [NUM_CASES] = '{
    "abcabc", "abcabc", "abc", "hello", "ab_cd", "abcd", "ab_ab",
    "", "a$b_ab", "", "x^y", "cat_dog", "aaab", "abab"
};

string case_pattern [NUM_CASES] = '{
    "bc", "xy", "abcdef", "l.o", "^cd", "^cd", "ab$",
    "b$", "a$b", "^ab$", "x^y", ".o.", "^aab", "ab$"
};

// first occurrence, missing, longer than string, dot
// caret after underscore, caret not satisfied, dollar before underscore
// reused string, literal dollar, both anchors on the reused string
// literal caret, dots around a literal, caret at position 0 only
// dollar skips an earlier hit and takes the one at the string end
bit case_match [NUM_CASES] = '{
    1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1,
    1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1
};

int case_index [NUM_CASES] = '{
    1, 0, 0, 2, 3, 0, 0,
    1, 0, 4, 0, 4, 0, 2
};

`endif

/* sim/sme_tb.sv */
`timescale 1ns/10ps

module sme_tb;
    import sme_char_pkg::*;
    import sme_cfg_pkg::*;

    localparam int STRING_LENGTH = STRING_LENGTH_DEF;
    localparam int PATTERN_LENGTH = PATTERN_LENGTH_DEF;
    localparam int IDX_W = $clog2(STRING_LENGTH);
    localparam int WAIT_LIMIT = STRING_LENGTH + 8;

    `include "sme_cases.svh"

    // limit in ns from 100 cycles per case plus reset
    localparam int WATCHDOG_NS = (NUM_CASES * 100 + 10) * 10;

    logic clk;
    logic reset;
    char_t chardata;
    logic isstring;
    logic ispattern;
    logic valid;
    logic match;
    logic [IDX_W-1:0] match_index;

    integer seed;
    int pass_count;
    int fail_count;

    sme_top #(
        .STRING_LENGTH  (STRING_LENGTH),
        .PATTERN_LENGTH (PATTERN_LENGTH)
    ) uut (
        .clk         (clk),
        .reset       (reset),
        .chardata    (chardata),
        .isstring    (isstring),
        .ispattern   (ispattern),
        .valid       (valid),
        .match       (match),
        .match_index (match_index)
    );

    always #5 clk = ~clk;

    // one character per falling edge and the strobe stays up after the last
    task automatic drive_burst(input string text, input bit as_pattern);
        for (int i = 0; i < text.len(); i++)
        begin
            @(negedge clk);
            chardata = text[i];
            isstring = !as_pattern;
            ispattern = as_pattern;
        end
    endtask

    task automatic go_idle();
        @(negedge clk);
        chardata = CHAR_NONE;
        isstring = 1'b0;
        ispattern = 1'b0;
    endtask

    task automatic check_reset_state();
        if (valid !== 1'b0 || match !== 1'b0 || match_index !== '0)
        begin
            $display("** Error at %0t: after reset valid=%b match=%b index=%0d",
                $time, valid, match, match_index);
            fail_count++;
        end
        else
        begin
            $display("reset: outputs idle");
            pass_count++;
        end
    endtask

    task automatic run_case(input int n);
        int gap;
        int waited;
        if (case_text[n].len() > 0)
        begin
            drive_burst(case_text[n], 1'b0);
            gap = int'($unsigned($random(seed)) % 4);
            repeat (gap) go_idle();
        end
        drive_burst(case_pattern[n], 1'b1);
        go_idle();
        waited = 0;
        while (!valid && waited < WAIT_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (!valid)
        begin
            $display("case %0d: no valid within %0d cycles, sequencer state %0d",
                n, WAIT_LIMIT, uut.u_control.state);
            fail_count++;
        end
        else if (match !== case_match[n] || match_index !== IDX_W'(case_index[n]))
        begin
            $display("** Error at %0t: case %0d \"%s\" / \"%s\" got %b/%0d, expected %b/%0d",
                $time, n, case_text[n], case_pattern[n], match, match_index,
                case_match[n], case_index[n]);
            fail_count++;
        end
        else
        begin
            $display("case %0d: \"%s\" matched %b at %0d", n, case_pattern[n],
                match, match_index);
            pass_count++;
        end
    endtask

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        chardata = CHAR_NONE;
        isstring = 1'b0;
        ispattern = 1'b0;
        seed = 32'h4b04;
        pass_count = 0;
        fail_count = 0;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_reset_state();
        for (int n = 0; n < NUM_CASES; n++)
            run_case(n);
        $display("%0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all cases finished");
        $display("sim failed");
        $finish;
    end

endmodule

/* sources.f */
+incdir+sim
hdl/sme_char_pkg.sv
hdl/sme_cfg_pkg.sv
hdl/sme_control.sv
hdl/string_buffer.sv
hdl/pattern_loader.sv
hdl/match_scanner.sv
hdl/sme_top.sv
sim/sme_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f sources.f --top-module sme_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vsme_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
